// File: filelist.f
hw/booth_mul_pkg.sv
hw/booth_recoder.sv
hw/booth_pp_row.sv
hw/booth_csa_tree.sv
hw/booth_final_adder.sv
hw/booth_mul_top.sv
tests/booth_mul_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Mdir obj_dir
TOP       ?= booth_mul_tb
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then decide the result from the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: tests/booth_mul_tb.sv
`timescale 1ns/1ps

module booth_mul_tb;

  import booth_mul_pkg::*;

  localparam int num_corner_lp     = 10;
  localparam int num_stream_lp     = 200;
  localparam int num_gap_ops_lp    = 100;
  localparam int max_gap_lp        = 4;
  localparam int num_pre_reset_lp  = 6;
  localparam int num_post_reset_lp = 20;
  localparam int reset_hold_lp     = 3;
  localparam int quiet_lp          = 5;

  localparam int total_ops_lp = 2 * num_corner_lp + num_stream_lp + num_gap_ops_lp
                              + num_pre_reset_lp + num_post_reset_lp;
  localparam int idle_lp      = 4 + num_gap_ops_lp * max_gap_lp + reset_hold_lp + quiet_lp
                              + 5 * (latency_lp + 2);
  localparam int timeout_lp   = 2 * (total_ops_lp + idle_lp) + 50;

  localparam operand_t ucorner_a_lp [num_corner_lp] = '{16'h0000, 16'h0000, 16'h0001,
    16'h0001, 16'hffff, 16'h8000, 16'haaaa, 16'h5555, 16'haaaa, 16'hffff};
  localparam operand_t ucorner_b_lp [num_corner_lp] = '{16'h0000, 16'hffff, 16'h0001,
    16'hffff, 16'hffff, 16'h8000, 16'h5555, 16'haaaa, 16'haaaa, 16'h0001};
  // -32768, 32767, -1 and mixed signs.
  localparam operand_t scorner_a_lp [num_corner_lp] = '{16'h8000, 16'h8000, 16'hffff,
    16'h7fff, 16'hffff, 16'h8000, 16'h0003, 16'hfffe, 16'h7fff, 16'haaaa};
  localparam operand_t scorner_b_lp [num_corner_lp] = '{16'h8000, 16'h7fff, 16'hffff,
    16'h7fff, 16'h0001, 16'hffff, 16'hfffd, 16'h0005, 16'h8000, 16'h5555};

  logic     clk;
  logic     reset_i, v_i, signed_i;
  operand_t a_i, b_i;
  logic     v_o;
  product_t product_o;

  int       cycle = 0;
  integer   seed;
  int       checks_passed = 0;
  int       checks_failed = 0;
  int       other_errors  = 0;
  int       issued_count  = 0;
  int       seen_count    = 0;
  product_t exp_q [$];       // expected products in issue order.
  int       issue_q [$];

  booth_mul_top dut0
    (.clk_i    (clk)
     ,.reset_i  (reset_i)
     ,.v_i      (v_i)
     ,.a_i      (a_i)
     ,.b_i      (b_i)
     ,.signed_i (signed_i)
     ,.v_o      (v_o)
     ,.product_o(product_o)
     );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= timeout_lp)
    begin
      $display("timeout after %0d cycles, products still outstanding", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  // operands read as signed or unsigned, multiplied at full width.
  function automatic product_t expected_product(input operand_t a, input operand_t b,
                                                input logic sgn);
    longint x, y, p;
    if (sgn)
    begin
      x = longint'($signed(a));
      y = longint'($signed(b));
    end
    else
    begin
      x = longint'(a);
      y = longint'(b);
    end
    p = x * y;
    return p[product_width_lp-1:0];
  endfunction

  task automatic compare_values(input string name, input product_t expected,
                                input product_t actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      checks_failed++;
    end
    else
      checks_passed++;
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk)
  begin : scoreboard
    product_t exp_val;
    int       iss;
    if (v_o)
    begin
      seen_count++;
      if (exp_q.size() == 0)
      begin
        $display("v_o at %0t arrived with no operation in flight", $time);
        other_errors++;
      end
      else
      begin
        exp_val = exp_q.pop_front();
        iss     = issue_q.pop_front();
        compare_values("product_o", exp_val, product_o);
        if (cycle - iss != latency_lp)
        begin
          $display("v_o at %0t came %0d cycles after its v_i instead of %0d",
                   $time, cycle - iss, latency_lp);
          other_errors++;
        end
      end
    end
    while (issue_q.size() != 0 && cycle - issue_q[0] > latency_lp)
    begin
      $display("operation issued in cycle %0d never produced v_o", issue_q[0]);
      other_errors++;
      exp_val = exp_q.pop_front();
      iss     = issue_q.pop_front();
    end
    if (reset_i)
    begin
      exp_q.delete();        // reset drops everything in flight.
      issue_q.delete();
    end
    else if (v_i)
    begin
      exp_q.push_back(expected_product(a_i, b_i, signed_i));
      issue_q.push_back(cycle);
      issued_count++;
    end
  end

  task automatic issue_op(input operand_t a, input operand_t b, input logic sgn);
    @(posedge clk);
    v_i      <= 1'b1;
    a_i      <= a;
    b_i      <= b;
    signed_i <= sgn;
  endtask

  task automatic issue_random();
    int       r;
    operand_t a, b;
    a = operand_t'($random(seed));
    b = operand_t'($random(seed));
    r = $random(seed);
    issue_op(a, b, r[0]);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      v_i <= 1'b0;
    end
  endtask

  task automatic drain();
    @(posedge clk);
    v_i <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s done, %0d errors", name, checks_failed + other_errors - errors_before);
  endtask

  initial
  begin : main
    int errs, gap, issued_before, seen_before;
    seed     = 32'he9a6_2bda;
    v_i      <= 1'b0;
    a_i      <= '0;
    b_i      <= '0;
    signed_i <= 1'b0;
    reset_i  <= 1'b1;
    repeat (4) @(posedge clk);
    reset_i  <= 1'b0;

    errs = checks_failed + other_errors;
    for (int i = 0; i < num_corner_lp; i++)
      issue_op(ucorner_a_lp[i], ucorner_b_lp[i], 1'b0);
    drain();
    report_test("unsigned corners", errs);

    errs = checks_failed + other_errors;
    for (int i = 0; i < num_corner_lp; i++)
      issue_op(scorner_a_lp[i], scorner_b_lp[i], 1'b1);
    drain();
    report_test("signed corners", errs);

    errs = checks_failed + other_errors;
    for (int i = 0; i < num_stream_lp; i++)
      issue_random();
    drain();
    report_test("back to back stream", errs);

    errs          = checks_failed + other_errors;
    issued_before = issued_count;
    seen_before   = seen_count;
    for (int i = 0; i < num_gap_ops_lp; i++)
    begin
      issue_random();
      gap = int'({$random(seed)} % (max_gap_lp + 1));
      idle(gap);
    end
    drain();
    compare_values("v_o pulse count", product_t'(issued_count - issued_before),
                   product_t'(seen_count - seen_before));
    report_test("idle gaps", errs);

    errs = checks_failed + other_errors;
    for (int i = 0; i < num_pre_reset_lp; i++)
      issue_random();
    @(posedge clk);
    v_i     <= 1'b0;
    reset_i <= 1'b1;
    @(posedge clk);
    seen_before = seen_count;  // last legal pulse is behind us.
    repeat (reset_hold_lp - 1) @(posedge clk);
    reset_i <= 1'b0;
    idle(quiet_lp);
    compare_values("v_o pulses after reset", '0, product_t'(seen_count - seen_before));
    for (int i = 0; i < num_post_reset_lp; i++)
      issue_random();
    drain();
    report_test("reset in flight", errs);

    $display("checks passed %0d, checks failed %0d, other errors %0d",
             checks_passed, checks_failed, other_errors);
    if (checks_failed == 0 && other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hw/booth_mul_top.sv
`timescale 1ns/1ps

module booth_mul_top
  (input                                clk_i
   , input                              reset_i
   , input                              v_i
   , input  booth_mul_pkg::operand_t    a_i
   , input  booth_mul_pkg::operand_t    b_i
   , input                              signed_i
   , output logic                       v_o
   , output booth_mul_pkg::product_t    product_o
   );

  import booth_mul_pkg::*;

  logic                     rec_v;
  ext_operand_t             multiplicand;
  sdn_t [num_digits_lp-1:0] sdn;

  pp_t  [num_digits_lp-1:0] pp;
  logic [num_digits_lp-1:0] neg;

  logic tree_v;
  acc_t tree_sum, tree_carry;

  // stage 1.
  booth_recoder recoder
    (.clk_i          (clk_i)
     ,.reset_i       (reset_i)
     ,.v_i           (v_i)
     ,.a_i           (a_i)
     ,.b_i           (b_i)
     ,.signed_i      (signed_i)
     ,.v_o           (rec_v)
     ,.multiplicand_o(multiplicand)
     ,.sdn_o         (sdn)
     );

  // one row per booth digit.
  for (genvar i = 0; i < num_digits_lp; i++)
  begin : rof
    booth_pp_row row
      (.sdn_i         (sdn[i])
       ,.multiplicand_i(multiplicand)
       ,.pp_o         (pp[i])
       ,.neg_o        (neg[i])
       );
  end

  // stage 2.
  booth_csa_tree tree
    (.clk_i    (clk_i)
     ,.reset_i (reset_i)
     ,.v_i     (rec_v)
     ,.pp_i    (pp)
     ,.neg_i   (neg)
     ,.v_o     (tree_v)
     ,.sum_o   (tree_sum)
     ,.carry_o (tree_carry)
     );

  // stage 3.
  booth_final_adder adder
    (.clk_i     (clk_i)
     ,.reset_i  (reset_i)
     ,.v_i      (tree_v)
     ,.sum_i    (tree_sum)
     ,.carry_i  (tree_carry)
     ,.v_o      (v_o)
     ,.product_o(product_o)
     );

endmodule

// File: hw/booth_final_adder.sv
`timescale 1ns/1ps

module booth_final_adder
  (input                                clk_i
   , input                              reset_i
   , input                              v_i
   , input  booth_mul_pkg::acc_t        sum_i
   , input  booth_mul_pkg::acc_t        carry_i
   , output logic                       v_o
   , output booth_mul_pkg::product_t    product_o
   );

  import booth_mul_pkg::*;

  acc_t total;

  // carry-propagate add, the full 36-bit result wraps cleanly.
  assign total = sum_i + carry_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_o <= 1'b0;
    else
      v_o <= v_i;
  end

  // low 32 bits match in both modes.
  always_ff @(posedge clk_i)
  begin
    if (v_i)
      product_o <= total[product_width_lp-1:0];
  end

endmodule

// File: hw/booth_csa_tree.sv
`timescale 1ns/1ps

module booth_csa_tree
  (input                                                       clk_i
   , input                                                     reset_i
   , input                                                     v_i
   , input  booth_mul_pkg::pp_t [booth_mul_pkg::num_digits_lp-1:0] pp_i
   , input  [booth_mul_pkg::num_digits_lp-1:0]                 neg_i
   , output logic                                              v_o
   , output booth_mul_pkg::acc_t                               sum_o
   , output booth_mul_pkg::acc_t                               carry_o
   );

  import booth_mul_pkg::*;

  // nine rows plus one vector with the negation bits and the correction.
  localparam int num_ops_lp = num_digits_lp + 1;

  acc_t corr_neg;
  acc_t lvl0 [num_ops_lp];
  acc_t lvl1 [7];
  acc_t lvl2 [5];
  acc_t lvl3 [4];
  acc_t lvl4 [3];
  acc_t sum_n, carry_n;

  function automatic void csa(input acc_t a,
                              input acc_t b,
                              input acc_t c,
                              output acc_t s,
                              output acc_t co);
    s  = a ^ b ^ c;
    co = ((a & b) | (a & c) | (b & c)) << 1;
  endfunction

  // negation bits sit on even positions 0..16, the correction only on odd ones.
  always_comb
  begin
    corr_neg = sign_corr_lp;
    for (int i = 0; i < num_digits_lp; i++)
    begin
      corr_neg[2*i] = neg_i[i];
    end
  end

  // row i shifted by two per booth digit.
  always_comb
  begin
    for (int i = 0; i < num_digits_lp; i++)
    begin
      lvl0[i] = acc_t'(pp_i[i]) << (2 * i);
    end
    lvl0[num_digits_lp] = corr_neg;
  end

  // 10 -> 7.
  always_comb
  begin
    for (int g = 0; g < 3; g++)
    begin
      csa(lvl0[3*g], lvl0[3*g+1], lvl0[3*g+2], lvl1[2*g], lvl1[2*g+1]);
    end
    lvl1[6] = lvl0[9];
  end

  // 7 -> 5.
  always_comb
  begin
    for (int g = 0; g < 2; g++)
    begin
      csa(lvl1[3*g], lvl1[3*g+1], lvl1[3*g+2], lvl2[2*g], lvl2[2*g+1]);
    end
    lvl2[4] = lvl1[6];
  end

  // 5 -> 4.
  always_comb
  begin
    csa(lvl2[0], lvl2[1], lvl2[2], lvl3[0], lvl3[1]);
    lvl3[2] = lvl2[3];
    lvl3[3] = lvl2[4];
  end

  // 4 -> 3.
  always_comb
  begin
    csa(lvl3[0], lvl3[1], lvl3[2], lvl4[0], lvl4[1]);
    lvl4[2] = lvl3[3];
  end

  // 3 -> 2, carries out of bit 35 drop off, the product is taken mod 2^36.
  always_comb
  begin
    csa(lvl4[0], lvl4[1], lvl4[2], sum_n, carry_n);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_o <= 1'b0;
    else
      v_o <= v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      sum_o   <= sum_n;
      carry_o <= carry_n;
    end
  end

endmodule

// File: hw/booth_pp_row.sv
`timescale 1ns/1ps

module booth_pp_row
  (input  booth_mul_pkg::sdn_t         sdn_i
   , input  booth_mul_pkg::ext_operand_t multiplicand_i
   , output booth_mul_pkg::pp_t        pp_o
   , output logic                      neg_o
   );

  import booth_mul_pkg::*;

  localparam int mag_width_lp = ext_width_lp + 1;

  logic                    sign, dbl, nonzero;
  logic [mag_width_lp-1:0] mag;
  logic [mag_width_lp-1:0] x;

  assign sign    = sdn_i[sdn_sign_bit_lp];
  assign dbl     = sdn_i[sdn_double_bit_lp];
  assign nonzero = sdn_i[sdn_nonzero_bit_lp];

  // magnitude select, kept signed over one extra bit so 2x cannot overflow.
  always_comb
  begin
    if (!nonzero)
      mag = '0;
    else if (dbl)
      mag = {multiplicand_i, 1'b0};
    else
      mag = {multiplicand_i[ext_width_lp-1], multiplicand_i};
  end

  // ones' complement for negative digits.
  assign x = mag ^ {mag_width_lp{sign}};

  // the +1 of the two's complement goes to the tree at this row's lsb.
  assign neg_o = sign;

  // constant 1 on top, then the inverted sign, then the low bits.
  assign pp_o = {1'b1, ~x[mag_width_lp-1], x[mag_width_lp-2:0]};

endmodule

// File: hw/booth_recoder.sv
`timescale 1ns/1ps

module booth_recoder
  (input                                                        clk_i
   , input                                                      reset_i
   , input                                                      v_i
   , input  booth_mul_pkg::operand_t                            a_i
   , input  booth_mul_pkg::operand_t                            b_i
   , input                                                      signed_i
   , output logic                                               v_o
   , output booth_mul_pkg::ext_operand_t                        multiplicand_o
   , output booth_mul_pkg::sdn_t [booth_mul_pkg::num_digits_lp-1:0] sdn_o
   );

  import booth_mul_pkg::*;

  ext_operand_t a_ext, b_ext;
  logic [2*num_digits_lp:0] b_win;           // multiplier with implicit zero below bit 0.
  sdn_t [num_digits_lp-1:0] sdn_n;

  // one radix-4 window {y2, y1, y0} into sign, double and nonzero.
  function automatic sdn_t encode(input logic [2:0] w);
    sdn_t d;
    d[sdn_sign_bit_lp]    = w[2] & ~(w[1] & w[0]);   // 111 is a plain zero.
    d[sdn_double_bit_lp]  = (w[2] & ~w[1] & ~w[0]) | (~w[2] & w[1] & w[0]);
    d[sdn_nonzero_bit_lp] = ~((w[2] == w[1]) && (w[1] == w[0]));
    return d;
  endfunction

  assign a_ext = {signed_i & a_i[operand_width_lp-1], a_i};
  assign b_ext = {signed_i & b_i[operand_width_lp-1], b_i};

  // top digit reads one more copy of the extended sign.
  assign b_win = {b_ext[ext_width_lp-1], b_ext, 1'b0};

  always_comb
  begin
    for (int i = 0; i < num_digits_lp; i++)
    begin
      sdn_n[i] = encode(b_win[2*i +: 3]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_o <= 1'b0;
    else
      v_o <= v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      multiplicand_o <= a_ext;
      sdn_o          <= sdn_n;
    end
  end

endmodule

// File: hw/booth_mul_pkg.sv
package booth_mul_pkg;

  localparam int operand_width_lp = 16;
  localparam int ext_width_lp     = operand_width_lp + 1; // room for the sign or zero bit.
  localparam int num_digits_lp    = 9;
  localparam int pp_width_lp      = ext_width_lp + 2;
  localparam int product_width_lp = 2 * operand_width_lp;
  localparam int latency_lp       = 3;

  // rows land at offsets 0, 2, .. 16, each pp_width_lp wide.
  localparam int acc_width_lp     = 2 * (num_digits_lp - 1) + pp_width_lp + 1;

  typedef logic [operand_width_lp-1:0] operand_t;
  typedef logic [ext_width_lp-1:0]     ext_operand_t;
  typedef logic [2:0]                  sdn_t;
  typedef logic [pp_width_lp-1:0]      pp_t;
  typedef logic [product_width_lp-1:0] product_t;
  typedef logic [acc_width_lp-1:0]     acc_t;

  // bit positions inside one booth digit triplet.
  localparam int sdn_sign_bit_lp    = 2;
  localparam int sdn_double_bit_lp  = 1;
  localparam int sdn_nonzero_bit_lp = 0;

  // every row carries a constant 1 on top and an inverted sign below it,
  // which biases row i by 3 * 2^17 * 4^i.
  // the sum of those biases is 2^17 * (4^n - 1), and this constant is its negation.
  localparam acc_t sign_corr_lp =
    acc_t'((64'd1 << (pp_width_lp - 2))
         - (64'd1 << (pp_width_lp - 2 + 2 * num_digits_lp)));

endpackage
